// File: logic/sba_pkg.sv
// Shared constants and types of the system bus access unit
// Only 64-bit accesses and 32-bit addresses are supported
package sba_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and memory size
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned SbDataWidth  = 32;
  localparam int unsigned SbWordWidth  = 64;
  // 256 words of 8 bytes, so byte addresses from 2048 up are out of range
  localparam int unsigned SbMemWords   = 256;
  localparam int unsigned SbIndexWidth = 8;

  ////////////////////////////////////////////////////////////////////////////
  // DMI register addresses
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [DmiAddrWidth-1:0] DmiSbcs       = 7'h38;
  localparam logic [DmiAddrWidth-1:0] DmiSbAddress0 = 7'h39;
  localparam logic [DmiAddrWidth-1:0] DmiSbData0    = 7'h3C;
  localparam logic [DmiAddrWidth-1:0] DmiSbData1    = 7'h3D;

  ////////////////////////////////////////////////////////////////////////////
  // SBCS layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SbcsBusyError  = 22;
  localparam int unsigned SbcsBusy       = 21;
  localparam int unsigned SbcsReadOnAddr = 20;
  // Three bits wide
  localparam int unsigned SbcsAccessLsb  = 17;
  localparam int unsigned SbcsAutoIncr   = 16;
  localparam int unsigned SbcsReadOnData = 15;
  // Three bits wide
  localparam int unsigned SbcsErrorLsb   = 12;

  // Version 1, 32-bit addresses, 64-bit access only
  localparam logic [SbDataWidth-1:0] SbcsConstBits = {
    3'd1, 17'd0, 7'd32, 1'b0, 1'b1, 3'd0
  };

  localparam logic [2:0] SbAccess64 = 3'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    dmi_read  = 1'b0,
    dmi_write = 1'b1
  } dmi_op_e;

  typedef enum logic [2:0] {
    sb_reg_none     = 3'd0,
    sb_reg_sbcs     = 3'd1,
    sb_reg_address0 = 3'd2,
    sb_reg_data0    = 3'd3,
    sb_reg_data1    = 3'd4
  } sb_reg_e;

  // Codes follow the sberror field of the debug spec
  typedef enum logic [2:0] {
    sb_err_none     = 3'd0,
    sb_err_bad_addr = 3'd2,
    sb_err_align    = 3'd3,
    sb_err_size     = 3'd4
  } sb_error_e;

endpackage

// File: logic/dmi_decoder.sv
// First pipeline stage, one request per cycle and no stall
// Unknown register addresses pass through as the none register
`timescale 1ns/1ns

module dmi_decoder (
  input  logic                                clk_sys,
  input  logic                                rst_n_i,

  // Raw host request
  input  logic                                dmi_valid_i,
  input  sba_pkg::dmi_op_e                    dmi_op_i,
  input  logic [sba_pkg::DmiAddrWidth-1:0]    dmi_addr_i,
  input  logic [sba_pkg::SbDataWidth-1:0]     dmi_wdata_i,

  // Decoded request, one cycle later
  output logic                                req_valid_o,
  output sba_pkg::dmi_op_e                    req_op_o,
  output sba_pkg::sb_reg_e                    req_reg_o,
  output logic [sba_pkg::SbDataWidth-1:0]     req_wdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  sba_pkg::sb_reg_e reg_dec;

  always_comb begin
    case (dmi_addr_i)
      sba_pkg::DmiSbcs: begin
        reg_dec = sba_pkg::sb_reg_sbcs;
      end
      sba_pkg::DmiSbAddress0: begin
        reg_dec = sba_pkg::sb_reg_address0;
      end
      sba_pkg::DmiSbData0: begin
        reg_dec = sba_pkg::sb_reg_data0;
      end
      sba_pkg::DmiSbData1: begin
        reg_dec = sba_pkg::sb_reg_data1;
      end
      default: begin
        // SBAddress1 and every other DM register land here
        reg_dec = sba_pkg::sb_reg_none;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request register
  ////////////////////////////////////////////////////////////////////////////

  // Valid strobe
  always_ff @(posedge clk_sys or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= dmi_valid_i;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk_sys) begin
    if (dmi_valid_i) begin
      req_op_o    <= dmi_op_i;
      req_reg_o   <= reg_dec;
      req_wdata_o <= dmi_wdata_i;
    end
  end

endmodule

// File: logic/sb_sequencer.sv
// Holds the system bus registers and launches one 64-bit access at a time
// Requests that collide with a busy access are dropped and flag sbbusyerror
`timescale 1ns/1ns

module sb_sequencer (
  input  logic                                clk_sys,
  input  logic                                rst_n_i,

  // Decoded register request
  input  logic                                req_valid_i,
  input  sba_pkg::dmi_op_e                    req_op_i,
  input  sba_pkg::sb_reg_e                    req_reg_i,
  input  logic [sba_pkg::SbDataWidth-1:0]     req_wdata_i,

  // Read response
  output logic                                dmi_rvalid_o,
  output logic [sba_pkg::SbDataWidth-1:0]     dmi_rdata_o,

  // Memory command and acknowledge
  output logic                                mem_req_o,
  output logic                                mem_we_o,
  output logic [sba_pkg::SbIndexWidth-1:0]    mem_index_o,
  output logic [sba_pkg::SbWordWidth-1:0]     mem_wdata_o,
  input  logic                                mem_ack_i,
  input  logic [sba_pkg::SbWordWidth-1:0]     mem_rdata_i
);

  // SBCS control and status
  logic                 sb_busy;
  logic                 sb_busy_error;
  sba_pkg::sb_error_e   sb_error;
  logic                 sb_read_on_addr;
  logic [2:0]           sb_access;
  logic                 sb_auto_incr;
  logic                 sb_read_on_data;

  logic [sba_pkg::SbDataWidth-1:0] sb_address0;
  logic [sba_pkg::SbDataWidth-1:0] sb_data0;
  logic [sba_pkg::SbDataWidth-1:0] sb_data1;

  logic wr_req;
  logic rd_req;
  logic sbcs_wr;
  logic busy_hit;
  logic trigger_write;
  logic trigger_read;
  logic start;
  logic launch;
  logic [sba_pkg::SbDataWidth-1:0] acc_addr;
  sba_pkg::sb_error_e              acc_err;
  logic [sba_pkg::SbDataWidth-1:0] rdata_mux;

  ////////////////////////////////////////////////////////////////////////////
  // Request classification
  ////////////////////////////////////////////////////////////////////////////

  assign wr_req  = req_valid_i && (req_op_i == sba_pkg::dmi_write);
  assign rd_req  = req_valid_i && (req_op_i == sba_pkg::dmi_read);
  assign sbcs_wr = wr_req && (req_reg_i == sba_pkg::sb_reg_sbcs);

  // SBCS stays writable while busy
  assign busy_hit = sb_busy && (
    (wr_req && (req_reg_i inside {sba_pkg::sb_reg_address0, sba_pkg::sb_reg_data0,
                                  sba_pkg::sb_reg_data1})) ||
    (rd_req && (req_reg_i == sba_pkg::sb_reg_data0)));

  assign trigger_write = !sb_busy && wr_req && (req_reg_i == sba_pkg::sb_reg_data0);
  assign trigger_read  = !sb_busy && (
    (wr_req && (req_reg_i == sba_pkg::sb_reg_address0) && sb_read_on_addr) ||
    (rd_req && (req_reg_i == sba_pkg::sb_reg_data0) && sb_read_on_data));

  // Sticky errors hold off every new access
  assign start  = (trigger_write || trigger_read) && !sb_busy_error &&
                  (sb_error == sba_pkg::sb_err_none);
  assign launch = start && (acc_err == sba_pkg::sb_err_none);

  // Read-on-address uses the address being written
  assign acc_addr = (req_reg_i == sba_pkg::sb_reg_address0) ? req_wdata_i : sb_address0;

  // Size first, then alignment, then range
  always_comb begin
    acc_err = sba_pkg::sb_err_none;
    if (sb_access != sba_pkg::SbAccess64) begin
      acc_err = sba_pkg::sb_err_size;
    end else if (acc_addr[2:0] != 3'b000) begin
      acc_err = sba_pkg::sb_err_align;
    end else if (acc_addr[sba_pkg::SbDataWidth-1:sba_pkg::SbIndexWidth+3] != '0) begin
      acc_err = sba_pkg::sb_err_bad_addr;
    end
  end

  // Register read mux
  always_comb begin
    rdata_mux = '0;
    case (req_reg_i)
      sba_pkg::sb_reg_sbcs: begin
        rdata_mux = sba_pkg::SbcsConstBits;
        rdata_mux[sba_pkg::SbcsBusyError]      = sb_busy_error;
        rdata_mux[sba_pkg::SbcsBusy]           = sb_busy;
        rdata_mux[sba_pkg::SbcsReadOnAddr]     = sb_read_on_addr;
        rdata_mux[sba_pkg::SbcsAccessLsb +: 3] = sb_access;
        rdata_mux[sba_pkg::SbcsAutoIncr]       = sb_auto_incr;
        rdata_mux[sba_pkg::SbcsReadOnData]     = sb_read_on_data;
        rdata_mux[sba_pkg::SbcsErrorLsb +: 3]  = sb_error;
      end
      sba_pkg::sb_reg_address0: rdata_mux = sb_address0;
      sba_pkg::sb_reg_data0:    rdata_mux = sb_data0;
      sba_pkg::sb_reg_data1:    rdata_mux = sb_data1;
      default:                  rdata_mux = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dmi_rvalid_o    <= 1'b0;
      mem_req_o       <= 1'b0;
      sb_busy         <= 1'b0;
      sb_busy_error   <= 1'b0;
      sb_error        <= sba_pkg::sb_err_none;
      sb_read_on_addr <= 1'b0;
      sb_access       <= 3'd0;
      sb_auto_incr    <= 1'b0;
      sb_read_on_data <= 1'b0;
      sb_address0     <= '0;
      sb_data0        <= '0;
      sb_data1        <= '0;
    end else begin
      dmi_rvalid_o <= rd_req;
      mem_req_o    <= launch;

      if (launch) begin
        sb_busy <= 1'b1;
      end else if (mem_ack_i) begin
        sb_busy <= 1'b0;
      end

      // Error flags, set by the request or cleared by writing ones
      if (busy_hit) begin
        sb_busy_error <= 1'b1;
      end else if (sbcs_wr && req_wdata_i[sba_pkg::SbcsBusyError]) begin
        sb_busy_error <= 1'b0;
      end
      if (start && (acc_err != sba_pkg::sb_err_none)) begin
        sb_error <= acc_err;
      end else if (sbcs_wr) begin
        sb_error <= sba_pkg::sb_error_e'(sb_error & ~req_wdata_i[sba_pkg::SbcsErrorLsb +: 3]);
      end

      if (sbcs_wr) begin
        sb_read_on_addr <= req_wdata_i[sba_pkg::SbcsReadOnAddr];
        sb_access       <= req_wdata_i[sba_pkg::SbcsAccessLsb +: 3];
        sb_auto_incr    <= req_wdata_i[sba_pkg::SbcsAutoIncr];
        sb_read_on_data <= req_wdata_i[sba_pkg::SbcsReadOnData];
      end

      if (wr_req && !sb_busy) begin
        case (req_reg_i)
          sba_pkg::sb_reg_address0: sb_address0 <= req_wdata_i;
          sba_pkg::sb_reg_data0:    sb_data0    <= req_wdata_i;
          sba_pkg::sb_reg_data1:    sb_data1    <= req_wdata_i;
          default: ;
        endcase
      end

      // Access done, ack never overlaps a register write since busy is still set
      if (mem_ack_i) begin
        if (!mem_we_o) begin
          sb_data0 <= mem_rdata_i[31:0];
          sb_data1 <= mem_rdata_i[63:32];
        end
        if (sb_auto_incr) begin
          sb_address0 <= sb_address0 + 32'd8;
        end
      end
    end
  end

  // Response and command payload
  always_ff @(posedge clk_sys) begin
    if (rd_req) begin
      dmi_rdata_o <= rdata_mux;
    end
    if (launch) begin
      mem_we_o    <= trigger_write;
      mem_index_o <= acc_addr[sba_pkg::SbIndexWidth+2:3];
      mem_wdata_o <= {sb_data1, req_wdata_i};
    end
  end

endmodule

// File: logic/sb_memory.sv
// Single-port word memory, one access per request strobe
// Acknowledge and read data follow the request by one cycle
`timescale 1ns/1ns

module sb_memory (
  input  logic                                clk_sys,
  input  logic                                rst_n_i,

  input  logic                                mem_req_i,
  input  logic                                mem_we_i,
  input  logic [sba_pkg::SbIndexWidth-1:0]    mem_index_i,
  input  logic [sba_pkg::SbWordWidth-1:0]     mem_wdata_i,

  output logic                                mem_ack_o,
  output logic [sba_pkg::SbWordWidth-1:0]     mem_rdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  logic [sba_pkg::SbWordWidth-1:0] mem_q [sba_pkg::SbMemWords];

  always_ff @(posedge clk_sys) begin
    if (mem_req_i) begin
      if (mem_we_i) begin
        mem_q[mem_index_i] <= mem_wdata_i;
      end else begin
        mem_rdata_o <= mem_q[mem_index_i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Acknowledge
  ////////////////////////////////////////////////////////////////////////////

  // Every request is answered, reads and writes alike
  always_ff @(posedge clk_sys or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_ack_o <= 1'b0;
    end else begin
      mem_ack_o <= mem_req_i;
    end
  end

endmodule

// File: logic/sba_top.sv
// System bus access unit top, three-stage pipeline
// Reads answer two cycles after the request, writes give no response
`timescale 1ns/1ns

module sba_top (
  input  logic                                clk_sys,
  input  logic                                rst_n_i,

  // Host register requests
  input  logic                                dmi_valid_i,
  input  sba_pkg::dmi_op_e                    dmi_op_i,
  input  logic [sba_pkg::DmiAddrWidth-1:0]    dmi_addr_i,
  input  logic [sba_pkg::SbDataWidth-1:0]     dmi_wdata_i,

  // Read responses
  output logic                                dmi_rvalid_o,
  output logic [sba_pkg::SbDataWidth-1:0]     dmi_rdata_o
);

  // Decoder to sequencer
  logic                             req_valid;
  sba_pkg::dmi_op_e                 req_op;
  sba_pkg::sb_reg_e                 req_reg;
  logic [sba_pkg::SbDataWidth-1:0]  req_wdata;

  // Sequencer to memory
  logic                             mem_req;
  logic                             mem_we;
  logic [sba_pkg::SbIndexWidth-1:0] mem_index;
  logic [sba_pkg::SbWordWidth-1:0]  mem_wdata;
  logic                             mem_ack;
  logic [sba_pkg::SbWordWidth-1:0]  mem_rdata;

  dmi_decoder i_dmi_decoder (
    .clk_sys     ( clk_sys     ),
    .rst_n_i     ( rst_n_i     ),
    .dmi_valid_i ( dmi_valid_i ),
    .dmi_op_i    ( dmi_op_i    ),
    .dmi_addr_i  ( dmi_addr_i  ),
    .dmi_wdata_i ( dmi_wdata_i ),
    .req_valid_o ( req_valid   ),
    .req_op_o    ( req_op      ),
    .req_reg_o   ( req_reg     ),
    .req_wdata_o ( req_wdata   )
  );

  sb_sequencer i_sb_sequencer (
    .clk_sys      ( clk_sys      ),
    .rst_n_i      ( rst_n_i      ),
    .req_valid_i  ( req_valid    ),
    .req_op_i     ( req_op       ),
    .req_reg_i    ( req_reg      ),
    .req_wdata_i  ( req_wdata    ),
    .dmi_rvalid_o ( dmi_rvalid_o ),
    .dmi_rdata_o  ( dmi_rdata_o  ),
    .mem_req_o    ( mem_req      ),
    .mem_we_o     ( mem_we       ),
    .mem_index_o  ( mem_index    ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_ack_i    ( mem_ack      ),
    .mem_rdata_i  ( mem_rdata    )
  );

  sb_memory i_sb_memory (
    .clk_sys     ( clk_sys   ),
    .rst_n_i     ( rst_n_i   ),
    .mem_req_i   ( mem_req   ),
    .mem_we_i    ( mem_we    ),
    .mem_index_i ( mem_index ),
    .mem_wdata_i ( mem_wdata ),
    .mem_ack_o   ( mem_ack   ),
    .mem_rdata_o ( mem_rdata )
  );

endmodule

// File: sim/tb_clock.sv
// Free-running 20 ns clock and an active-low reset held for the first 16 cycles
`timescale 1ns/1ns

module tb_clock (
  output logic clk_sys,
  output logic rst_n_o
);

  // 10 ns half period
  initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
  end

  // Released on a rising edge like every other input
  initial begin
    rst_n_o <= 1'b0;
    repeat (16) @(posedge clk_sys);
    rst_n_o <= 1'b1;
  end

endmodule

// File: sim/tb_sba.sv
// Directed tests through DMI register requests stop at the first wrong value
// Memory words outside the tested range are never checked
`timescale 1ns/1ns

module tb_sba;

  localparam int unsigned BurstWords = 20;
  localparam logic [31:0] BaseAddr   = 32'h0000_0100;
  // 200 cycles for each of about 60 moved words plus a fixed margin
  localparam int unsigned LimitCycles = 60 * 200 + 2000;

  logic                              clk_sys;
  logic                              rst_n;
  logic                              dmi_valid_i;
  sba_pkg::dmi_op_e                  dmi_op_i;
  logic [sba_pkg::DmiAddrWidth-1:0]  dmi_addr_i;
  logic [sba_pkg::SbDataWidth-1:0]   dmi_wdata_i;
  logic                              dmi_rvalid_o;
  logic [sba_pkg::SbDataWidth-1:0]   dmi_rdata_o;

  logic [31:0] rng_state;
  logic [63:0] burst_words [BurstWords];
  // Read strobes seen on the last two falling edges, oldest in bit 1
  logic [1:0]  rd_pipe;

  tb_clock i_clock (
    .clk_sys ( clk_sys ),
    .rst_n_o ( rst_n   )
  );

  sba_top i_dut (
    .clk_sys      ( clk_sys      ),
    .rst_n_i      ( rst_n        ),
    .dmi_valid_i  ( dmi_valid_i  ),
    .dmi_op_i     ( dmi_op_i     ),
    .dmi_addr_i   ( dmi_addr_i   ),
    .dmi_wdata_i  ( dmi_wdata_i  ),
    .dmi_rvalid_o ( dmi_rvalid_o ),
    .dmi_rdata_o  ( dmi_rdata_o  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // SBCS control value with the error fields at zero
  function automatic logic [31:0] sbcs_cfg(input logic on_addr, input logic incr,
                                          input logic on_data, input logic [2:0] access);
    logic [31:0] v;
    v = 32'h0;
    v[sba_pkg::SbcsReadOnAddr]     = on_addr;
    v[sba_pkg::SbcsAutoIncr]       = incr;
    v[sba_pkg::SbcsReadOnData]     = on_data;
    v[sba_pkg::SbcsAccessLsb +: 3] = access;
    return v;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input sba_pkg::sb_error_e got,
                           input sba_pkg::sb_error_e exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic dmi_write(input logic [sba_pkg::DmiAddrWidth-1:0] addr,
                           input logic [31:0] data);
    @(posedge clk_sys);
    dmi_valid_i <= 1'b1;
    dmi_op_i    <= sba_pkg::dmi_write;
    dmi_addr_i  <= addr;
    dmi_wdata_i <= data;
    @(posedge clk_sys);
    dmi_valid_i <= 1'b0;
  endtask

  // Response sampled on the falling edge
  task automatic dmi_read(input logic [sba_pkg::DmiAddrWidth-1:0] addr,
                          output logic [31:0] data);
    int waited;
    @(posedge clk_sys);
    dmi_valid_i <= 1'b1;
    dmi_op_i    <= sba_pkg::dmi_read;
    dmi_addr_i  <= addr;
    @(posedge clk_sys);
    dmi_valid_i <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk_sys);
      waited++;
    end while (!dmi_rvalid_o && waited < 8);
    if (!dmi_rvalid_o) begin
      fail_run("read request got no response within 8 cycles");
    end else begin
      data = dmi_rdata_o;
    end
  endtask

  task automatic wait_not_busy();
    logic [31:0] sbcs;
    int polls;
    polls = 0;
    do begin
      dmi_read(sba_pkg::DmiSbcs, sbcs);
      polls++;
    end while (sbcs[sba_pkg::SbcsBusy] && polls < 50);
    if (sbcs[sba_pkg::SbcsBusy]) begin
      fail_run("sbbusy stayed set for 50 polls of SBCS");
    end
  endtask

  // Single read through readonaddr without increment
  task automatic read_word(input logic [31:0] addr, output logic [63:0] word);
    logic [31:0] hi;
    logic [31:0] lo;
    dmi_write(sba_pkg::DmiSbcs, sbcs_cfg(1'b1, 1'b0, 1'b0, sba_pkg::SbAccess64));
    dmi_write(sba_pkg::DmiSbAddress0, addr);
    wait_not_busy();
    dmi_read(sba_pkg::DmiSbData1, hi);
    dmi_read(sba_pkg::DmiSbData0, lo);
    word = {hi, lo};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    logic [31:0] val;
    dmi_read(sba_pkg::DmiSbcs, val);
    // Version 1, 32 address bits, 64-bit access supported
    check_reg("sbcs after reset", val, (32'd1 << 29) | (32'd32 << 5) | (32'd1 << 3));
    dmi_read(sba_pkg::DmiSbAddress0, val);
    check_reg("sbaddress0 after reset", val, 32'h0);
    dmi_read(sba_pkg::DmiSbData0, val);
    check_reg("sbdata0 after reset", val, 32'h0);
    dmi_read(sba_pkg::DmiSbData1, val);
    check_reg("sbdata1 after reset", val, 32'h0);
  endtask

  task automatic test_burst();
    logic [31:0] hi;
    logic [31:0] lo;
    int i;
    dmi_write(sba_pkg::DmiSbcs, sbcs_cfg(1'b0, 1'b1, 1'b0, sba_pkg::SbAccess64));
    dmi_write(sba_pkg::DmiSbAddress0, BaseAddr);
    for (i = 0; i < BurstWords; i++) begin
      burst_words[i] = {next_rand(), next_rand()};
      dmi_write(sba_pkg::DmiSbData1, burst_words[i][63:32]);
      dmi_write(sba_pkg::DmiSbData0, burst_words[i][31:0]);
      wait_not_busy();
    end
    dmi_read(sba_pkg::DmiSbAddress0, lo);
    check_reg("sbaddress0 after burst write", lo, BaseAddr + 8 * BurstWords);
    dmi_write(sba_pkg::DmiSbcs, sbcs_cfg(1'b1, 1'b1, 1'b1, sba_pkg::SbAccess64));
    dmi_write(sba_pkg::DmiSbAddress0, BaseAddr);
    wait_not_busy();
    for (i = 0; i < BurstWords; i++) begin
      dmi_read(sba_pkg::DmiSbData1, hi);
      dmi_read(sba_pkg::DmiSbData0, lo);
      check_word($sformatf("burst word %0d", i), {hi, lo}, burst_words[i]);
      wait_not_busy();
    end
    // The last SBData0 read also fetched the word past the burst
    dmi_read(sba_pkg::DmiSbAddress0, lo);
    check_reg("sbaddress0 after burst read", lo, BaseAddr + 8 * (BurstWords + 1));
  endtask

  task automatic test_single_read();
    logic [63:0] word;
    logic [31:0] addr;
    addr = BaseAddr + 8 * 7;
    read_word(addr, word);
    check_word("single read word 7", word, burst_words[7]);
    dmi_read(sba_pkg::DmiSbAddress0, addr);
    check_reg("sbaddress0 after single read", addr, BaseAddr + 8 * 7);
  endtask

  // Write attempt that must fail and leave burst word 0 untouched
  task automatic provoke_write_error(input logic [31:0] cfg, input logic [31:0] addr,
                                     input sba_pkg::sb_error_e exp, input string what);
    logic [31:0] sbcs;
    logic [63:0] word;
    dmi_write(sba_pkg::DmiSbcs, cfg);
    dmi_write(sba_pkg::DmiSbAddress0, addr);
    dmi_write(sba_pkg::DmiSbData1, next_rand());
    dmi_write(sba_pkg::DmiSbData0, next_rand());
    dmi_read(sba_pkg::DmiSbcs, sbcs);
    check_err({"sberror on ", what}, sba_pkg::sb_error_e'(sbcs[sba_pkg::SbcsErrorLsb +: 3]),
              exp);
    check_reg({"sbbusy on ", what}, {31'd0, sbcs[sba_pkg::SbcsBusy]}, 32'd0);
    dmi_write(sba_pkg::DmiSbcs, cfg | (32'h7 << sba_pkg::SbcsErrorLsb));
    dmi_read(sba_pkg::DmiSbcs, sbcs);
    check_err({"sberror cleared after ", what},
              sba_pkg::sb_error_e'(sbcs[sba_pkg::SbcsErrorLsb +: 3]), sba_pkg::sb_err_none);
    read_word(BaseAddr, word);
    check_word({"memory after ", what}, word, burst_words[0]);
  endtask

  task automatic test_errors();
    logic [31:0] cfg;
    cfg = sbcs_cfg(1'b0, 1'b0, 1'b0, sba_pkg::SbAccess64);
    // Out of range address aliases onto word 0 in the index bits
    provoke_write_error(cfg, BaseAddr + 32'h800, sba_pkg::sb_err_bad_addr, "bad address");
    provoke_write_error(cfg, BaseAddr + 32'd4, sba_pkg::sb_err_align, "misaligned address");
    provoke_write_error(sbcs_cfg(1'b0, 1'b0, 1'b0, 3'd2), BaseAddr, sba_pkg::sb_err_size,
                        "32-bit access size");
  endtask

  task automatic test_busy_error();
    logic [31:0] sbcs;
    logic [31:0] second;
    logic [31:0] target;
    logic [63:0] first;
    logic [63:0] word;
    target = BaseAddr + 8 * 30;
    first  = {next_rand(), next_rand()};
    second = next_rand();
    dmi_write(sba_pkg::DmiSbcs, sbcs_cfg(1'b0, 1'b0, 1'b0, sba_pkg::SbAccess64));
    dmi_write(sba_pkg::DmiSbAddress0, target);
    dmi_write(sba_pkg::DmiSbData1, first[63:32]);
    // The second of two back-to-back SBData0 strobes hits busy
    @(posedge clk_sys);
    dmi_valid_i <= 1'b1;
    dmi_op_i    <= sba_pkg::dmi_write;
    dmi_addr_i  <= sba_pkg::DmiSbData0;
    dmi_wdata_i <= first[31:0];
    @(posedge clk_sys);
    dmi_wdata_i <= second;
    @(posedge clk_sys);
    dmi_valid_i <= 1'b0;
    wait_not_busy();
    dmi_read(sba_pkg::DmiSbcs, sbcs);
    check_reg("sbbusyerror", {31'd0, sbcs[sba_pkg::SbcsBusyError]}, 32'd1);
    dmi_write(sba_pkg::DmiSbcs, sbcs_cfg(1'b0, 1'b0, 1'b0, sba_pkg::SbAccess64) |
              (32'd1 << sba_pkg::SbcsBusyError));
    dmi_read(sba_pkg::DmiSbcs, sbcs);
    check_reg("sbbusyerror after clear", {31'd0, sbcs[sba_pkg::SbcsBusyError]}, 32'd0);
    read_word(target, word);
    check_word("word after busy error", word, first);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence, response monitor and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rng_state = 32'h1462;
    dmi_valid_i <= 1'b0;
    dmi_op_i    <= sba_pkg::dmi_read;
    dmi_addr_i  <= '0;
    dmi_wdata_i <= '0;
    wait (rst_n == 1'b1);
    repeat (2) @(posedge clk_sys);
    test_reset();
    test_burst();
    test_single_read();
    test_errors();
    test_busy_error();
    $display("STATUS: PASS");
    $finish;
  end

  // Each read answers exactly two cycles after its strobe and writes never answer
  initial begin
    rd_pipe = 2'b00;
    forever begin
      @(negedge clk_sys);
      check_flag("dmi_rvalid_o", dmi_rvalid_o, rd_pipe[1]);
      rd_pipe = {rd_pipe[0], dmi_valid_i && (dmi_op_i == sba_pkg::dmi_read)};
    end
  end

  initial begin
    repeat (LimitCycles) @(posedge clk_sys);
    fail_run($sformatf("timeout, tests did not finish within %0d cycles", LimitCycles));
  end

endmodule

// File: project.f
logic/sba_pkg.sv
logic/dmi_decoder.sv
logic/sb_sequencer.sv
logic/sb_memory.sv
logic/sba_top.sv
sim/tb_clock.sv
sim/tb_sba.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it, exit status follows the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_sba -o tb_sba_sim \
  && ./obj_dir/tb_sba_sim | tee /dev/stderr | grep -qx "STATUS: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

exit 0
